//--- sim/lcd_tests.txt
# cmd args (hex unless noted): W addr data | R addr expect | F addr count data | L addr min
# M mode(dec) | I V/S | A V/S | C line(dec) shades(160 hex digits, left to right)
W FF40 11
R FF40 11
R FF44 00
R FF41 04
W FF41 FF
W FF45 07
R FF41 F8
W FF44 33
R FF44 00
W FF42 5A
R FF42 5A
W FF43 3C
R FF43 3C
W FF47 1B
R FF47 1B
W FF41 00
W FF42 00
W FF43 00
W FF47 E4
W FF45 00
R FF46 FF
F 9800 20 01
W 9801 02
W 8010 F0
W 8011 CC
W 8020 81
W 8021 3C
F 9820 20 FF
W 9820 00
W 9000 0F
W 9001 55
W 8FF0 AA
W 8FF1 0F
R 8010 F0
R 9001 55
W FF40 91
I V
R FF41 01
L FF44 90
A V
W FF45 05
W FF41 40
I S
R FF44 05
W FF41 00
A S
M 3
R 8010 FF
W 8010 77
M 0
R 8010 F0
C 0 3311220010222201331122003311220033112200331122003311220033112200331122003311220033112200331122003311220033112200331122003311220033112200331122003311220033112200
W FF47 1B
W FF43 03
W FF42 08
W FF40 81
C 0 1202023230101232301012323010123230101232301012323010123230101232301012323010123230101232301012323010123230101232301012323010123230101232301012323010123230101232
W FF40 80
C 2 3333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333333

//--- filelist.f
verilog/lcd_pkg.sv
verilog/lcd_regs.sv
verilog/lcd_timing.sv
verilog/lcd_irq.sv
verilog/vram.sv
verilog/bg_fetch.sv
verilog/lcd_top.sv
sim/lcd_chk.sv
sim/lcd_tb.sv

//--- sim/lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb
   import lcd_pkg::*;
();

   localparam int FRAME_CLOCKS = DOTS_PER_LINE * LINES_PER_FRAME * DOT_DIV;
   localparam int OTHER_CLOCKS = 100;
   localparam time DRIVE = 2ns;

   logic      clock, reset, mem_enable, rd_n, wr_n;
   cpu_addr_t addr;
   byte_t     wdata, rdata;
   logic      int_vblank_ack, int_lcdc_ack, int_vblank_req, int_lcdc_req;
   logic      hsync, vsync, pixel_we;
   shade_t    pixel_data;

   string     cmds[$];
   int        limit, cycles, errors, cap_count;
   logic      armed;
   shade_t    cap [0:VISIBLE_PIXELS-1];

   lcd_top uut (
      .clock(clock), .reset(reset), .mem_enable(mem_enable), .rd_n(rd_n), .wr_n(wr_n),
      .addr(addr), .wdata(wdata), .rdata(rdata), .int_vblank_ack(int_vblank_ack),
      .int_lcdc_ack(int_lcdc_ack), .int_vblank_req(int_vblank_req),
      .int_lcdc_req(int_lcdc_req), .hsync(hsync), .vsync(vsync),
      .pixel_data(pixel_data), .pixel_we(pixel_we)
   );

   // 40 ns period
   always #20 clock = ~clock;

   ////////////////////////////////////////
   // Timeout and pixel capture
   ////////////////////////////////////////
   always @(posedge clock) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout: run went past %0d clocks", limit);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // Collect strobed pixels while a capture is armed
   always @(posedge clock) begin
      if (armed && pixel_we) begin
         if (cap_count < VISIBLE_PIXELS) begin
            cap[cap_count] = pixel_data;
         end
         cap_count++;
      end
   end

   // Stop on the first failed checker assertion
   always @(posedge clock) begin
      if (uut.u_chk.errors_seen != 0) begin
         fail_now("An assertion in the bound checker lcd_chk failed");
      end
   end

   task automatic fail_now(input string msg);
      errors++;
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "check failed");
   endtask

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////
   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         fail_now($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_shade(input string name, input shade_t got, input shade_t exp);
      if (got !== exp) begin
         fail_now($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_now($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // Bus cycles of one clock each
   task automatic bus_write(input cpu_addr_t a, input byte_t d);
      @(posedge clock);
      #DRIVE;
      mem_enable = 1'b1;
      wr_n = 1'b0;
      addr = a;
      wdata = d;
      @(posedge clock);
      #DRIVE;
      mem_enable = 1'b0;
      wr_n = 1'b1;
   endtask

   // Registered read data is valid after the sampling edge
   task automatic bus_read(input cpu_addr_t a, output byte_t d);
      @(posedge clock);
      #DRIVE;
      mem_enable = 1'b1;
      rd_n = 1'b0;
      addr = a;
      @(posedge clock);
      #DRIVE;
      mem_enable = 1'b0;
      rd_n = 1'b1;
      d = rdata;
   endtask

   task automatic wait_mode(input int m);
      byte_t s;
      do begin
         bus_read(ADDR_STAT, s);
      end while (s[1:0] != 2'(m));
   endtask

   task automatic wait_irq(input string which);
      do begin
         @(posedge clock);
         #DRIVE;
      end while (!((which == "V") ? int_vblank_req : int_lcdc_req));
      // V-Blank request arrives in the blanking lines
      if (which == "V") begin
         check_flag("vsync", vsync, 1'b1);
      end
   endtask

   // One clock ack pulse and a check that the request has dropped
   task automatic ack_irq(input string which);
      @(posedge clock);
      #DRIVE;
      int_vblank_ack = (which == "V");
      int_lcdc_ack = (which != "V");
      @(posedge clock);
      #DRIVE;
      int_vblank_ack = 1'b0;
      int_lcdc_ack = 1'b0;
      if (which == "V") begin
         check_flag("int_vblank_req", int_vblank_req, 1'b0);
      end else begin
         check_flag("int_lcdc_req", int_lcdc_req, 1'b0);
      end
   endtask

   ////////////////////////////////////////
   // Line capture
   ////////////////////////////////////////
   task automatic capture_line(input int n, input string pix);
      byte_t s;
      byte_t l;
      int    i;
      if (pix.len() != VISIBLE_PIXELS) begin
         fail_now($sformatf("Expected row for line %0d is not 160 digits long", n));
      end
      // Park in mode 2 of the wanted line
      do begin
         bus_read(ADDR_STAT, s);
         bus_read(ADDR_LY, l);
      end while (!(s[1:0] == MODE_OAM && l == line_t'(n)));
      cap_count = 0;
      armed = 1'b1;
      // Start of a visible line, no sync yet
      check_flag("hsync", hsync, 1'b0);
      check_flag("vsync", vsync, 1'b0);
      // hsync comes after mode 3 has ended
      do begin
         @(posedge clock);
         #DRIVE;
      end while (!hsync);
      armed = 1'b0;
      check_flag("vsync", vsync, 1'b0);
      if (cap_count != VISIBLE_PIXELS) begin
         fail_now($sformatf("Line %0d gave %0d pixel strobes instead of 160", n, cap_count));
      end
      for (i = 0; i < VISIBLE_PIXELS; i++) begin
         check_shade($sformatf("pixel_data[%0d] of line %0d", i, n), cap[i],
                     shade_t'(pix.getc(i) - 8'h30));
      end
   endtask

   task automatic run_command(input string line);
      string cmd;
      string arg;
      int    a;
      int    d;
      int    cnt;
      int    i;
      byte_t got;
      void'($sscanf(line, "%s", cmd));
      case (cmd)
         "W": begin
            void'($sscanf(line, "%s %h %h", cmd, a, d));
            bus_write(cpu_addr_t'(a), byte_t'(d));
         end
         "R": begin
            void'($sscanf(line, "%s %h %h", cmd, a, d));
            bus_read(cpu_addr_t'(a), got);
            check_byte($sformatf("rdata at %h", a), got, byte_t'(d));
         end
         // Block fill of one value
         "F": begin
            void'($sscanf(line, "%s %h %h %h", cmd, a, cnt, d));
            for (i = 0; i < cnt; i++) begin
               bus_write(cpu_addr_t'(a + i), byte_t'(d));
            end
         end
         "L": begin
            void'($sscanf(line, "%s %h %h", cmd, a, d));
            bus_read(cpu_addr_t'(a), got);
            check_flag($sformatf("rdata at %h >= %h", a, d), got >= byte_t'(d), 1'b1);
         end
         "M": begin
            void'($sscanf(line, "%s %d", cmd, d));
            wait_mode(d);
         end
         "I": begin
            void'($sscanf(line, "%s %s", cmd, arg));
            wait_irq(arg);
         end
         "A": begin
            void'($sscanf(line, "%s %s", cmd, arg));
            ack_irq(arg);
         end
         "C": begin
            void'($sscanf(line, "%s %d %s", cmd, d, arg));
            capture_line(d, arg);
         end
         default: fail_now($sformatf("Unknown command in the data file: %s", line));
      endcase
   endtask

   // Read commands and size the timeout from them
   task automatic load_tests();
      int    fd;
      string line;
      string cmd;
      fd = $fopen("sim/lcd_tests.txt", "r");
      if (fd == 0) begin
         fail_now("Could not open sim/lcd_tests.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0 && line.getc(0) != "#" && $sscanf(line, "%s", cmd) == 1) begin
            cmds.push_back(line);
         end
      end
      $fclose(fd);
      limit = 10;
      foreach (cmds[i]) begin
         cmd = cmds[i].substr(0, 0);
         if (cmd == "I" || cmd == "M" || cmd == "C") begin
            limit += 3 * FRAME_CLOCKS;
         end else begin
            limit += OTHER_CLOCKS;
         end
      end
   endtask

   initial begin
      clock = 1'b0;
      reset = 1'b1;
      mem_enable = 1'b0;
      rd_n = 1'b1;
      wr_n = 1'b1;
      addr = '0;
      wdata = '0;
      int_vblank_ack = 1'b0;
      int_lcdc_ack = 1'b0;
      armed = 1'b0;
      cap_count = 0;
      cycles = 0;
      limit = 0;
      errors = 0;
      load_tests();
      repeat (5) @(posedge clock);
      #DRIVE;
      reset = 1'b0;
      // Outputs are quiet straight out of reset
      check_flag("int_vblank_req", int_vblank_req, 1'b0);
      check_flag("int_lcdc_req", int_lcdc_req, 1'b0);
      check_flag("pixel_we", pixel_we, 1'b0);
      check_flag("hsync", hsync, 1'b0);
      check_flag("vsync", vsync, 1'b0);
      foreach (cmds[i]) begin
         run_command(cmds[i]);
      end
      repeat (4) @(posedge clock);
      if (errors == 0 && uut.u_chk.errors_seen == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- sim/lcd_chk.sv
`timescale 1ns/1ps

module lcd_chk
   import lcd_pkg::*;
(
   input logic      clock,
   input logic      reset,
   input lcd_mode_t mode,
   input logic      pixel_we,
   input logic      int_vblank_req,
   input logic      int_lcdc_req
);

   // Count of assertion failures watched by the testbench
   int errors_seen = 0;

   ////////////////////////////////////////
   // Pixel strobe window
   ////////////////////////////////////////
   pix_in_transfer: assert property (@(posedge clock) disable iff (reset)
      pixel_we |-> mode == MODE_TRANSFER)
      else begin
         errors_seen++;
         $error("pixel_we strobed outside mode 3");
      end

   // V-Blank request only on entry to mode 1
   vblank_on_entry: assert property (@(posedge clock) disable iff (reset)
      $rose(int_vblank_req) |-> ($past(mode) == MODE_VBLANK) && ($past(mode, 2) != MODE_VBLANK))
      else begin
         errors_seen++;
         $error("int_vblank_req rose without a mode 1 entry");
      end

   // Both requests clear right after reset
   quiet_after_reset: assert property (@(posedge clock)
      $fell(reset) |-> !int_vblank_req && !int_lcdc_req)
      else begin
         errors_seen++;
         $error("interrupt request high in the cycle after reset");
      end

endmodule

bind lcd_top lcd_chk u_chk (
   .clock(clock), .reset(reset), .mode(mode), .pixel_we(pixel_we),
   .int_vblank_req(int_vblank_req), .int_lcdc_req(int_lcdc_req)
);

//--- verilog/lcd_top.sv
`timescale 1ns/1ps

module lcd_top
   import lcd_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      mem_enable,
   input  logic      rd_n,
   input  logic      wr_n,
   input  cpu_addr_t addr,
   input  byte_t     wdata,
   output byte_t     rdata,
   input  logic      int_vblank_ack,
   input  logic      int_lcdc_ack,
   output logic      int_vblank_req,
   output logic      int_lcdc_req,
   output logic      hsync,
   output logic      vsync,
   output shade_t    pixel_data,
   output logic      pixel_we
);

   logic       vram_sel, reg_sel, vram_rd_q, reg_rd_q;
   logic       dot_tick, lcd_on, map_sel, tile_sel, bg_on, lyc_match;
   logic [3:0] stat_enables;
   dot_t       dot;
   line_t      ly;
   lcd_mode_t  mode;
   byte_t      scx, scy, bgp, reg_rdata, vram_rdata, render_data;
   vram_addr_t render_addr;

   ////////////////////////////////////////
   // Bus decode
   ////////////////////////////////////////
   assign vram_sel = mem_enable && (addr >= VRAM_BASE) && (addr <= VRAM_END);
   // FF46 falls inside and reads open bus from the register file
   assign reg_sel  = mem_enable && (addr >= ADDR_LCDC) && (addr <= ADDR_BGP);

   // Remember who answers the read on the next clock
   always_ff @(posedge clock) begin
      if (reset) begin
         vram_rd_q <= 1'b0;
         reg_rd_q  <= 1'b0;
      end else begin
         vram_rd_q <= vram_sel && !rd_n;
         reg_rd_q  <= reg_sel && !rd_n;
      end
   end

   assign rdata = vram_rd_q ? vram_rdata : (reg_rd_q ? reg_rdata : OPEN_BUS);

   lcd_regs u_regs (
      .clock(clock), .reset(reset), .reg_sel(reg_sel), .rd_n(rd_n), .wr_n(wr_n),
      .addr(addr), .wdata(wdata), .mode(mode), .ly(ly), .reg_rdata(reg_rdata),
      .lcd_on(lcd_on), .map_sel(map_sel), .tile_sel(tile_sel), .bg_on(bg_on),
      .scx(scx), .scy(scy), .lyc(), .bgp(bgp), .stat_enables(stat_enables),
      .lyc_match(lyc_match)
   );

   lcd_timing u_timing (
      .clock(clock), .reset(reset), .lcd_on(lcd_on), .dot_tick(dot_tick),
      .dot(dot), .ly(ly), .mode(mode), .hsync(hsync), .vsync(vsync)
   );

   lcd_irq u_irq (
      .clock(clock), .reset(reset), .mode(mode), .lyc_match(lyc_match), .dot(dot),
      .stat_enables(stat_enables), .int_vblank_ack(int_vblank_ack),
      .int_lcdc_ack(int_lcdc_ack), .int_vblank_req(int_vblank_req),
      .int_lcdc_req(int_lcdc_req)
   );

   // CPU offset into the 8 KiB window
   vram u_vram (
      .clock(clock), .vram_sel(vram_sel), .wr_n(wr_n),
      .cpu_addr(vram_addr_t'(addr - VRAM_BASE)), .wdata(wdata), .mode(mode),
      .cpu_rdata(vram_rdata), .render_addr(render_addr), .render_data(render_data)
   );

   bg_fetch u_fetch (
      .clock(clock), .reset(reset), .dot_tick(dot_tick), .mode(mode), .ly(ly),
      .scx(scx), .scy(scy), .bgp(bgp), .map_sel(map_sel), .tile_sel(tile_sel),
      .bg_on(bg_on), .render_addr(render_addr), .render_data(render_data),
      .pixel_data(pixel_data), .pixel_we(pixel_we)
   );

endmodule

//--- verilog/bg_fetch.sv
`timescale 1ns/1ps

module bg_fetch
   import lcd_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       dot_tick,
   input  lcd_mode_t  mode,
   input  line_t      ly,
   input  byte_t      scx,
   input  byte_t      scy,
   input  byte_t      bgp,
   input  logic       map_sel,
   input  logic       tile_sel,
   input  logic       bg_on,
   output vram_addr_t render_addr,
   input  byte_t      render_data,
   output shade_t     pixel_data,
   output logic       pixel_we
);

   fetch_state_t state;
   lcd_mode_t    mode_q;
   logic         start, active, emit, fill, load;
   logic         buf_full, first;
   logic [3:0]   sh_cnt;
   logic [7:0]   pix_cnt;
   logic [2:0]   fine_x, drop;
   logic [4:0]   tile_x;
   line_t        bg_y;
   vram_addr_t   map_addr, row_addr, row_q, tile_off, tile_base;
   byte_t        lo_q, buf_lo, buf_hi, sh_lo, sh_hi;
   shade_t       color;

   assign start  = (mode == MODE_TRANSFER) && (mode_q != MODE_TRANSFER);
   // Line still in progress
   assign active = (mode == MODE_TRANSFER) && (pix_cnt < 8'(VISIBLE_PIXELS)) && !start;
   assign emit   = active && dot_tick && (sh_cnt != 4'd0);
   assign fill   = active && (state == FETCH_READY) && !buf_full;
   // Refill the shifter as its last pixel leaves
   assign load   = active && buf_full && ((sh_cnt == 4'd0) || (sh_cnt == 4'd1 && emit));
   // Fine scroll only trims the first tile
   assign drop   = first ? fine_x : 3'd0;

   ////////////////////////////////////////
   // VRAM address generation
   ////////////////////////////////////////
   assign map_addr  = (map_sel ? MAP1_BASE : MAP0_BASE) + {3'b000, bg_y[7:3], tile_x};
   // Index arrives on render_data in FETCH_LOW
   assign tile_off  = tile_sel ? {1'b0, render_data, 4'h0}
                               : {render_data[7], render_data, 4'h0};
   assign tile_base = tile_sel ? TILES_UNSIGNED_BASE : TILES_SIGNED_BASE;
   assign row_addr  = tile_base + tile_off + {9'd0, bg_y[2:0], 1'b0};

   always_comb begin
      case (state)
         FETCH_LOW:   render_addr = row_addr;
         // High byte sits right after the low byte
         FETCH_HIGH:  render_addr = row_q | 13'd1;
         FETCH_READY: render_addr = row_q | 13'd1;
         default:     render_addr = map_addr;
      endcase
   end

   // Control
   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= FETCH_IDLE;
         mode_q   <= MODE_HBLANK;
         buf_full <= 1'b0;
         sh_cnt   <= '0;
         pix_cnt  <= '0;
         first    <= 1'b0;
         pixel_we <= 1'b0;
      end else begin
         mode_q   <= mode;
         pixel_we <= emit;
         if (start) begin
            state   <= FETCH_MAP;
            pix_cnt <= '0;
            first   <= 1'b1;
         end else if (!active) begin
            state <= FETCH_IDLE;
         end else begin
            case (state)
               FETCH_MAP:   state <= FETCH_LOW;
               FETCH_LOW:   state <= FETCH_HIGH;
               FETCH_HIGH:  state <= FETCH_READY;
               // Hold the high byte until the buffer frees up
               FETCH_READY: if (fill) state <= FETCH_MAP;
               default:     state <= FETCH_IDLE;
            endcase
         end
         if (start || !active) begin
            buf_full <= 1'b0;
            sh_cnt   <= '0;
         end else begin
            if (fill) begin
               buf_full <= 1'b1;
            end else if (load) begin
               buf_full <= 1'b0;
            end
            if (load) begin
               sh_cnt <= 4'd8 - {1'b0, drop};
            end else if (emit) begin
               sh_cnt <= sh_cnt - 4'd1;
            end
         end
         if (load) begin
            first <= 1'b0;
         end
         if (emit) begin
            pix_cnt <= pix_cnt + 8'd1;
         end
      end
   end

   // Pixel index, MSB first, forced to 0 with the background off
   assign color = bg_on ? {sh_hi[7], sh_lo[7]} : 2'b00;

   // Datapath
   always_ff @(posedge clock) begin
      if (start) begin
         bg_y   <= scy + ly;
         tile_x <= scx[7:3];
         fine_x <= scx[2:0];
      end else if (fill) begin
         tile_x <= tile_x + 5'd1;
      end
      if (state == FETCH_LOW) begin
         row_q <= row_addr;
      end
      if (state == FETCH_HIGH) begin
         lo_q <= render_data;
      end
      // Prefetch buffer, second tile in flight
      if (fill) begin
         buf_lo <= lo_q;
         buf_hi <= render_data;
      end
      if (load) begin
         sh_lo <= buf_lo << drop;
         sh_hi <= buf_hi << drop;
      end else if (emit) begin
         sh_lo <= sh_lo << 1;
         sh_hi <= sh_hi << 1;
      end
      // BGP lookup
      if (emit) begin
         pixel_data <= bgp[{color, 1'b0} +: 2];
      end
   end

endmodule

//--- verilog/vram.sv
`timescale 1ns/1ps

module vram
   import lcd_pkg::*;
(
   input  logic       clock,
   input  logic       vram_sel,
   input  logic       wr_n,
   input  vram_addr_t cpu_addr,
   input  byte_t      wdata,
   input  lcd_mode_t  mode,
   output byte_t      cpu_rdata,
   input  vram_addr_t render_addr,
   output byte_t      render_data
);

   // 8 KiB, one byte per offset from VRAM_BASE
   byte_t mem [0:VRAM_END - VRAM_BASE];
   logic  locked;

   // Renderer owns the array during pixel transfer
   assign locked = (mode == MODE_TRANSFER);

   // Port A, CPU side
   always_ff @(posedge clock) begin
      if (vram_sel && !wr_n && !locked) begin
         mem[cpu_addr] <= wdata;
      end
      cpu_rdata <= locked ? OPEN_BUS : mem[cpu_addr];
   end

   // Port B, renderer side, never locked
   always_ff @(posedge clock) begin
      render_data <= mem[render_addr];
   end

endmodule

//--- verilog/lcd_irq.sv
`timescale 1ns/1ps

module lcd_irq
   import lcd_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  lcd_mode_t  mode,
   input  logic       lyc_match,
   input  dot_t       dot,
   input  logic [3:0] stat_enables,
   input  logic       int_vblank_ack,
   input  logic       int_lcdc_ack,
   output logic       int_vblank_req,
   output logic       int_lcdc_req
);

   lcd_mode_t mode_q;
   logic      lyc_hit_q;
   logic      lyc_hit;
   logic      enter_hblank;
   logic      enter_vblank;
   logic      enter_oam;
   logic      stat_set;

   // Mode entry edges
   assign enter_hblank = (mode == MODE_HBLANK) && (mode_q != MODE_HBLANK);
   assign enter_vblank = (mode == MODE_VBLANK) && (mode_q != MODE_VBLANK);
   assign enter_oam    = (mode == MODE_OAM) && (mode_q != MODE_OAM);

   // LYC compare is sampled at the start of a line
   assign lyc_hit = lyc_match && (dot == '0);

   assign stat_set = (enter_hblank && stat_enables[0]) ||
                     (enter_vblank && stat_enables[1]) ||
                     (enter_oam && stat_enables[2]) ||
                     (lyc_hit && !lyc_hit_q && stat_enables[3]);

   // Sticky requests, a new event beats a same-cycle ack
   always_ff @(posedge clock) begin
      if (reset) begin
         mode_q         <= MODE_HBLANK;
         lyc_hit_q      <= 1'b0;
         int_vblank_req <= 1'b0;
         int_lcdc_req   <= 1'b0;
      end else begin
         mode_q    <= mode;
         lyc_hit_q <= lyc_hit;
         if (enter_vblank) begin
            int_vblank_req <= 1'b1;
         end else if (int_vblank_ack) begin
            int_vblank_req <= 1'b0;
         end
         if (stat_set) begin
            int_lcdc_req <= 1'b1;
         end else if (int_lcdc_ack) begin
            int_lcdc_req <= 1'b0;
         end
      end
   end

endmodule

//--- verilog/lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing
   import lcd_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      lcd_on,
   output logic      dot_tick,
   output dot_t      dot,
   output line_t     ly,
   output lcd_mode_t mode,
   output logic      hsync,
   output logic      vsync
);

   logic [3:0] div_cnt;
   logic       line_end;

   ////////////////////////////////////////
   // Dot clock divider
   ////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset || !lcd_on) begin
         div_cnt <= '0;
      end else if (div_cnt == 4'(DOT_DIV - 1)) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 4'd1;
      end
   end

   assign dot_tick = lcd_on && (div_cnt == 4'(DOT_DIV - 1));
   assign line_end = (dot == dot_t'(DOTS_PER_LINE - 1));

   // Raster position, parked at 0,0 while the panel is off
   always_ff @(posedge clock) begin
      if (reset || !lcd_on) begin
         dot <= '0;
         ly  <= '0;
      end else if (dot_tick) begin
         if (line_end) begin
            dot <= '0;
            // Wrap after the last V-Blank line
            if (ly == line_t'(LINES_PER_FRAME - 1)) begin
               ly <= '0;
            end else begin
               ly <= ly + 8'd1;
            end
         end else begin
            dot <= dot + 9'd1;
         end
      end
   end

   // Mode windows follow the position directly
   always_comb begin
      if (!lcd_on) begin
         mode = MODE_HBLANK;
      end else if (ly >= line_t'(VISIBLE_LINES)) begin
         mode = MODE_VBLANK;
      end else if (dot < dot_t'(OAM_DOTS)) begin
         mode = MODE_OAM;
      end else if (dot < dot_t'(OAM_DOTS + TRANSFER_DOTS)) begin
         mode = MODE_TRANSFER;
      end else begin
         mode = MODE_HBLANK;
      end
   end

   // Sync pulses in the tail of each line and the blanking lines
   assign hsync = (dot >= dot_t'(OAM_DOTS + TRANSFER_DOTS + VISIBLE_PIXELS));
   assign vsync = (ly >= line_t'(VISIBLE_LINES));

endmodule

//--- verilog/lcd_regs.sv
`timescale 1ns/1ps

module lcd_regs
   import lcd_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      reg_sel,
   input  logic      rd_n,
   input  logic      wr_n,
   input  cpu_addr_t addr,
   input  byte_t     wdata,
   input  lcd_mode_t mode,
   input  line_t     ly,
   output byte_t     reg_rdata,
   output logic      lcd_on,
   output logic      map_sel,
   output logic      tile_sel,
   output logic      bg_on,
   output byte_t     scx,
   output byte_t     scy,
   output byte_t     lyc,
   output byte_t     bgp,
   output logic [3:0] stat_enables,
   output logic      lyc_match
);

   byte_t      lcdc;
   // STAT bits 7..3, the only writable part
   logic [4:0] stat_hi;
   byte_t      stat;

   // Coincidence flag
   assign lyc_match = (ly == lyc);

   // Upper bits, coincidence, live mode
   assign stat = {stat_hi, lyc_match, mode};

   // LCDC fields used by the datapath
   // Bits 6, 5, 2 and 1 are stored for read back only
   assign lcd_on   = lcdc[7];
   assign tile_sel = lcdc[4];
   assign map_sel  = lcdc[3];
   assign bg_on    = lcdc[0];

   // HBlank, VBlank, OAM, LYC sources
   assign stat_enables = stat_hi[3:0];

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         lcdc    <= LCDC_RESET;
         stat_hi <= '0;
         scy     <= '0;
         scx     <= '0;
         lyc     <= '0;
         bgp     <= BGP_RESET;
      end else if (reg_sel && !wr_n) begin
         case (addr)
            ADDR_LCDC: lcdc <= wdata;
            // Mode and coincidence bits stay read-only
            ADDR_STAT: stat_hi <= wdata[7:3];
            ADDR_SCY:  scy <= wdata;
            ADDR_SCX:  scx <= wdata;
            ADDR_LYC:  lyc <= wdata;
            ADDR_BGP:  bgp <= wdata;
            default: ;
         endcase
      end
   end

   // Read data, one clock behind the request
   always_ff @(posedge clock) begin
      if (reg_sel && !rd_n) begin
         case (addr)
            ADDR_LCDC: reg_rdata <= lcdc;
            ADDR_STAT: reg_rdata <= stat;
            ADDR_SCY:  reg_rdata <= scy;
            ADDR_SCX:  reg_rdata <= scx;
            ADDR_LY:   reg_rdata <= ly;
            ADDR_LYC:  reg_rdata <= lyc;
            ADDR_BGP:  reg_rdata <= bgp;
            default:   reg_rdata <= OPEN_BUS;
         endcase
      end
   end

endmodule

//--- verilog/lcd_pkg.sv
package lcd_pkg;

   ////////////////////////////////////////
   // Widths that carry a meaning
   ////////////////////////////////////////
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] cpu_addr_t;
   typedef logic [12:0] vram_addr_t;
   typedef logic [8:0]  dot_t;
   typedef logic [7:0]  line_t;
   typedef logic [1:0]  shade_t;

   // STAT mode flag encoding
   typedef enum logic [1:0] {
      MODE_HBLANK   = 2'd0,
      MODE_VBLANK   = 2'd1,
      MODE_OAM      = 2'd2,
      MODE_TRANSFER = 2'd3
   } lcd_mode_t;

   // Background fetcher steps
   typedef enum logic [2:0] {
      FETCH_IDLE,
      FETCH_MAP,
      FETCH_LOW,
      FETCH_HIGH,
      FETCH_READY
   } fetch_state_t;

   ////////////////////////////////////////
   // Raster timing, in dots and lines
   ////////////////////////////////////////
   localparam int DOTS_PER_LINE   = 456;
   localparam int LINES_PER_FRAME = 154;
   localparam int VISIBLE_LINES   = 144;
   localparam int VISIBLE_PIXELS  = 160;
   localparam int OAM_DOTS        = 80;
   localparam int TRANSFER_DOTS   = 172;
   // System clocks per dot
   localparam int DOT_DIV         = 2;

   ////////////////////////////////////////
   // Bus map and reset values
   ////////////////////////////////////////
   localparam cpu_addr_t ADDR_LCDC = 16'hFF40;
   localparam cpu_addr_t ADDR_STAT = 16'hFF41;
   localparam cpu_addr_t ADDR_SCY  = 16'hFF42;
   localparam cpu_addr_t ADDR_SCX  = 16'hFF43;
   localparam cpu_addr_t ADDR_LY   = 16'hFF44;
   localparam cpu_addr_t ADDR_LYC  = 16'hFF45;
   localparam cpu_addr_t ADDR_BGP  = 16'hFF47;

   localparam cpu_addr_t VRAM_BASE = 16'h8000;
   localparam cpu_addr_t VRAM_END  = 16'h9FFF;

   // Offsets inside VRAM, i.e. 0x9800/0x9C00 and 0x8000/0x9000 on the bus
   localparam vram_addr_t MAP0_BASE           = 13'h1800;
   localparam vram_addr_t MAP1_BASE           = 13'h1C00;
   localparam vram_addr_t TILES_UNSIGNED_BASE = 13'h0000;
   localparam vram_addr_t TILES_SIGNED_BASE   = 13'h1000;

   localparam byte_t LCDC_RESET = 8'h91;
   localparam byte_t BGP_RESET  = 8'hE4;
   localparam byte_t OPEN_BUS   = 8'hFF;

endpackage
